// File: source/gfx_pkg.sv
`default_nettype none

package gfx_pkg;

    // CPU register file
    localparam int reg_count = 8;
    localparam int reg_aw    = 3;

    // Visible line
    localparam int line_pxl = 32;
    localparam int pxl_w    = 5;

    // Four pixels per ROM word, eight words per layer line
    localparam int words_per_line = 8;
    localparam int rom_aw         = 18;

    // Register map
    localparam logic [reg_aw-1:0] reg_hscroll = 3'd0;
    localparam logic [reg_aw-1:0] reg_vscroll = 3'd2;

    // Bit 0 tile bank, bit 3 object page
    localparam logic [reg_aw-1:0] reg_bank = 3'd3;

    // Bits 5:4 palette bank, bit 3 tile priority
    localparam logic [reg_aw-1:0] reg_colour = 3'd6;

    // Bit 1 enables the IRQ, any write acknowledges it
    localparam logic [reg_aw-1:0] reg_irq = 3'd7;

    // Graphics ROM word
    // pxl[0] is the leftmost pixel, held in the top nibble
    typedef union packed {
        logic [15:0]     raw;
        logic [0:3][3:0] pxl;
    } rom_word_u;

endpackage

`default_nettype wire

// File: source/gfx_rom_if.sv
`timescale 1ns/1ps
`default_nettype none

// Path from one layer fetcher to the shared graphics ROM
interface gfx_rom_if;

    logic                       cs;
    logic [gfx_pkg::rom_aw-1:0] addr;
    logic                       ok;
    gfx_pkg::rom_word_u         data;

    // Keeps cs high and addr steady until ok
    modport requester (
        output cs,
        output addr,
        input  ok,
        input  data
    );

    // One-cycle ok, data valid in the same cycle
    modport arbiter (
        input  cs,
        input  addr,
        output ok,
        output data
    );

endinterface

`default_nettype wire

// File: source/gfx_regs.sv
`timescale 1ns/1ps
`default_nettype none

module gfx_regs (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        pxl_cen,
    input  wire                        lvbl,
    input  wire                        cs,
    input  wire                        cpu_rnw,
    input  wire                        cpu_cen,
    input  wire [gfx_pkg::reg_aw-1:0]  addr,
    input  wire [7:0]                  cpu_dout,
    output logic [7:0]                 dout,
    output logic                       cpu_irqn,
    output logic [gfx_pkg::pxl_w-1:0]  hscroll,
    output logic [7:0]                 vscroll,
    output logic                       tile_bank,
    output logic                       obj_page,
    output logic [1:0]                 pal_bank,
    output logic                       prio_en
);

    logic [7:0] mmr [gfx_pkg::reg_count];
    logic       reg_we;
    logic       irq_ack;
    logic       last_lvbl;

    assign reg_we  = cs && cpu_cen && !cpu_rnw;
    assign irq_ack = reg_we && (addr == gfx_pkg::reg_irq);

    // Register read back
    assign dout = mmr[addr];

    // Only part of the horizontal scroll matters on a 32-pixel line
    assign hscroll   = mmr[gfx_pkg::reg_hscroll][gfx_pkg::pxl_w-1:0];
    assign vscroll   = mmr[gfx_pkg::reg_vscroll];
    assign tile_bank = mmr[gfx_pkg::reg_bank][0];
    assign obj_page  = mmr[gfx_pkg::reg_bank][3];
    assign pal_bank  = mmr[gfx_pkg::reg_colour][5:4];
    assign prio_en   = mmr[gfx_pkg::reg_colour][3];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < gfx_pkg::reg_count; i++) begin
                mmr[i] <= 8'd0;
            end
        end else if (reg_we) begin
            mmr[addr] <= cpu_dout;
        end
    end

    // VBL interrupt, set on the falling edge of lvbl
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cpu_irqn  <= 1'b1;
            last_lvbl <= 1'b0;
        end else begin
            if (pxl_cen) begin
                last_lvbl <= lvbl;
                if (!lvbl && last_lvbl && mmr[gfx_pkg::reg_irq][1])
                    cpu_irqn <= 1'b0;
            end
            // Ack wins over a new edge in the same cycle
            if (irq_ack)
                cpu_irqn <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/gfx_rom_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module gfx_rom_arbiter (
    input  wire                          clk,
    input  wire                          rst,
    // Bit 0 tiles, bit 1 objects
    input  wire [1:0]                    gfx_en,
    input  wire [15:0]                   rom_data,
    input  wire                          rom_ok,
    gfx_rom_if.arbiter                   tile_rom,
    gfx_rom_if.arbiter                   obj_rom,
    output logic                         rom_cs,
    output logic [gfx_pkg::rom_aw-1:0]   rom_addr,
    output logic                         rom_obj_sel
);

    logic ok_wait;
    logic ext_take;
    logic tile_dis_wait;
    logic obj_dis_wait;
    logic tile_dis_take;
    logic obj_dis_take;
    logic tile_take;
    logic obj_take;

    // rom_ok counts only after the first waiting cycle
    assign ext_take = rom_cs && ok_wait && rom_ok;

    // Disabled layers get zero data two cycles after cs
    assign tile_dis_take = !gfx_en[0] && tile_rom.cs && !tile_rom.ok && tile_dis_wait;
    assign obj_dis_take  = !gfx_en[1] && obj_rom.cs && !obj_rom.ok && obj_dis_wait;

    assign tile_take = (ext_take && !rom_obj_sel) || tile_dis_take;
    assign obj_take  = (ext_take && rom_obj_sel) || obj_dis_take;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rom_cs        <= 1'b0;
            rom_addr      <= '0;
            rom_obj_sel   <= 1'b0;
            ok_wait       <= 1'b0;
            tile_dis_wait <= 1'b0;
            obj_dis_wait  <= 1'b0;
            tile_rom.ok   <= 1'b0;
            obj_rom.ok    <= 1'b0;
        end else begin
            tile_rom.ok   <= tile_take;
            obj_rom.ok    <= obj_take;
            tile_dis_wait <= !gfx_en[0] && tile_rom.cs && !tile_rom.ok && !tile_dis_take;
            obj_dis_wait  <= !gfx_en[1] && obj_rom.cs && !obj_rom.ok && !obj_dis_take;
            if (!rom_cs) begin
                // A requester seeing ok this cycle still shows its old cs
                if (tile_rom.cs && !tile_rom.ok && gfx_en[0]) begin
                    rom_cs      <= 1'b1;
                    rom_addr    <= tile_rom.addr;
                    rom_obj_sel <= 1'b0;
                    ok_wait     <= 1'b0;
                end else if (obj_rom.cs && !obj_rom.ok && gfx_en[1]) begin
                    rom_cs      <= 1'b1;
                    rom_addr    <= obj_rom.addr;
                    rom_obj_sel <= 1'b1;
                    ok_wait     <= 1'b0;
                end
            end else if (ext_take) begin
                rom_cs <= 1'b0;
            end else begin
                ok_wait <= 1'b1;
            end
        end
    end

    // Returned words
    always_ff @(posedge clk) begin
        if (tile_dis_take)
            tile_rom.data.raw <= 16'd0;
        else if (tile_take)
            tile_rom.data.raw <= rom_data;
        if (obj_dis_take)
            obj_rom.data.raw <= 16'd0;
        else if (obj_take)
            obj_rom.data.raw <= rom_data;
    end

endmodule

`default_nettype wire

// File: source/gfx_layer_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module gfx_layer_fetch (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        line_start,
    input  wire [7:0]                  vrender,
    input  wire [7:0]                  vscroll,
    input  wire                        bank,
    input  wire [gfx_pkg::pxl_w-1:0]   hdump,
    input  wire [gfx_pkg::pxl_w-1:0]   hscroll,
    gfx_rom_if.requester               rom,
    output logic [3:0]                 pxl
);

    // Two line halves picked by the top index bit
    logic [3:0] line_buf [2*gfx_pkg::line_pxl];

    logic                                       front;
    logic                                       busy;
    logic                                       fetch_bank;
    logic [7:0]                                 fetch_line;
    logic [$clog2(gfx_pkg::words_per_line)-1:0] word_cnt;
    logic [gfx_pkg::pxl_w-1:0]                  rd_pos;
    logic                                       word_in;

    assign rom.cs = busy;

    // Zero-extended bank, line and word index
    assign rom.addr = {{(gfx_pkg::rom_aw - $bits(word_cnt) - 9){1'b0}},
                       fetch_bank, fetch_line, word_cnt};

    // A restart at line_start drops any late word
    assign word_in = busy && rom.ok && !line_start;

    // Wraps modulo the line length
    assign rd_pos = hdump + hscroll;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            front      <= 1'b0;
            busy       <= 1'b0;
            fetch_bank <= 1'b0;
            fetch_line <= 8'd0;
            word_cnt   <= '0;
        end else if (line_start) begin
            front      <= ~front;
            busy       <= 1'b1;
            fetch_bank <= bank;
            fetch_line <= vrender + vscroll;
            word_cnt   <= '0;
        end else if (word_in) begin
            // Last word of the line
            if (&word_cnt)
                busy <= 1'b0;
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // Back half is filled, front half is shown
    always_ff @(posedge clk) begin
        if (word_in) begin
            for (int i = 0; i < 4; i++) begin
                line_buf[{~front, word_cnt, 2'(i)}] <= rom.data.pxl[i];
            end
        end
        // The swap clock already reads the new front half
        pxl <= line_buf[{front ^ line_start, rd_pos}];
    end

endmodule

`default_nettype wire

// File: source/gfx_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module gfx_mixer (
    input  wire         clk,
    input  wire         rst,
    input  wire         pxl_cen,
    input  wire         lhbl,
    input  wire         lvbl,
    input  wire  [3:0]  tile_pxl,
    input  wire  [3:0]  obj_pxl,
    input  wire  [1:0]  pal_bank,
    input  wire         prio_en,
    output logic [6:0]  pxl_out
);

    logic obj_blank;
    logic tile_blank;
    logic tile_show;

    // Index zero is transparent on both layers
    assign obj_blank  = (obj_pxl == 4'd0);
    assign tile_blank = (tile_pxl == 4'd0);

    // Tiles sit behind objects unless priority is on
    assign tile_show = obj_blank || (prio_en && !tile_blank);

    // Layer pixels arrive registered one clock earlier by the fetchers
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pxl_out <= 7'd0;
        end else if (pxl_cen) begin
            if (!lhbl || !lvbl)
                pxl_out <= 7'd0;
            else if (tile_show)
                pxl_out <= {pal_bank, 1'b1, tile_pxl};
            else
                pxl_out <= {pal_bank, 1'b0, obj_pxl};
        end
    end

endmodule

`default_nettype wire

// File: source/gfx_core.sv
`timescale 1ns/1ps
`default_nettype none

module gfx_core (
    input  wire                          clk,
    input  wire                          rst,
    // Video timing
    input  wire                          pxl_cen,
    input  wire                          line_start,
    input  wire                          lhbl,
    input  wire                          lvbl,
    input  wire [gfx_pkg::pxl_w-1:0]     hdump,
    input  wire [7:0]                    vrender,
    // CPU bus
    input  wire                          cs,
    input  wire                          cpu_rnw,
    input  wire                          cpu_cen,
    input  wire [gfx_pkg::reg_aw-1:0]    addr,
    input  wire [7:0]                    cpu_dout,
    // Graphics ROM
    input  wire [15:0]                   rom_data,
    input  wire                          rom_ok,
    // Test only, bit 0 tiles, bit 1 objects
    input  wire [1:0]                    gfx_en,
    output wire [7:0]                    dout,
    output wire                          cpu_irqn,
    output wire                          rom_cs,
    output wire [gfx_pkg::rom_aw-1:0]    rom_addr,
    output wire                          rom_obj_sel,
    output wire [6:0]                    pxl_out
);

    logic [gfx_pkg::pxl_w-1:0] hscroll;
    logic [7:0]                vscroll;
    logic                      tile_bank;
    logic                      obj_page;
    logic [1:0]                pal_bank;
    logic                      prio_en;
    logic [3:0]                tile_pxl;
    logic [3:0]                obj_pxl;

    gfx_rom_if tile_rom ();
    gfx_rom_if obj_rom ();

    gfx_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .lvbl      (lvbl),
        .cs        (cs),
        .cpu_rnw   (cpu_rnw),
        .cpu_cen   (cpu_cen),
        .addr      (addr),
        .cpu_dout  (cpu_dout),
        .dout      (dout),
        .cpu_irqn  (cpu_irqn),
        .hscroll   (hscroll),
        .vscroll   (vscroll),
        .tile_bank (tile_bank),
        .obj_page  (obj_page),
        .pal_bank  (pal_bank),
        .prio_en   (prio_en)
    );

    gfx_rom_arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .gfx_en      (gfx_en),
        .rom_data    (rom_data),
        .rom_ok      (rom_ok),
        .tile_rom    (tile_rom.arbiter),
        .obj_rom     (obj_rom.arbiter),
        .rom_cs      (rom_cs),
        .rom_addr    (rom_addr),
        .rom_obj_sel (rom_obj_sel)
    );

    gfx_layer_fetch u_tile_fetch (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .vrender    (vrender),
        .vscroll    (vscroll),
        .bank       (tile_bank),
        .hdump      (hdump),
        .hscroll    (hscroll),
        .rom        (tile_rom.requester),
        .pxl        (tile_pxl)
    );

    // Objects do not scroll
    gfx_layer_fetch u_obj_fetch (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .vrender    (vrender),
        .vscroll    (8'd0),
        .bank       (obj_page),
        .hdump      (hdump),
        .hscroll    ({gfx_pkg::pxl_w{1'b0}}),
        .rom        (obj_rom.requester),
        .pxl        (obj_pxl)
    );

    gfx_mixer u_mixer (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .tile_pxl (tile_pxl),
        .obj_pxl  (obj_pxl),
        .pal_bank (pal_bank),
        .prio_en  (prio_en),
        .pxl_out  (pxl_out)
    );

endmodule

`default_nettype wire

// File: verification/gfx_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gfx_core_tb;

    localparam int max_cycles = 6000;

    logic        clk = 1'b0;
    logic        rst;
    logic        pxl_cen;
    logic        line_start;
    logic        lhbl;
    logic        lvbl;
    logic [4:0]  hdump;
    logic [7:0]  vrender;
    logic        cs;
    logic        cpu_rnw;
    logic        cpu_cen;
    logic [2:0]  addr;
    logic [7:0]  cpu_dout;
    logic [15:0] rom_data;
    logic        rom_ok;
    logic [1:0]  gfx_en;
    wire  [7:0]  dout;
    wire         cpu_irqn;
    wire         rom_cs;
    wire  [17:0] rom_addr;
    wire         rom_obj_sel;
    wire  [6:0]  pxl_out;

    // Video position, ROM model state and shadow of the CPU registers
    int          clk_cnt = 0;
    int          vcnt = 0;
    int          cycles = 0;
    integer      seed = 32'ha123;
    logic        rom_pend = 1'b0;
    int          rcnt;
    int          wait_n;
    logic [7:0]  regs_m [8];
    // Layer parameters of the line being fetched and of the line on screen
    logic        fetch_tb = 1'b0;
    logic        fetch_ob = 1'b0;
    logic [7:0]  fetch_tl = 8'd0;
    logic [7:0]  fetch_ol = 8'd0;
    logic [1:0]  fetch_en = 2'b11;
    logic        shown_tb = 1'b0;
    logic        shown_ob = 1'b0;
    logic [7:0]  shown_tl = 8'd0;
    logic [7:0]  shown_ol = 8'd0;
    logic [1:0]  shown_en = 2'b11;
    int          lines_seen = 0;
    int          tile_req = 0;
    int          obj_req = 0;
    logic        prev_cs = 1'b0;
    logic [17:0] prev_addr = '0;
    logic        prev_sel = 1'b0;
    logic [6:0]  exp_pxl = 7'd0;
    logic        exp_ok = 1'b0;
    logic        pix_on = 1'b0;
    logic        dis_phase = 1'b0;
    int          errs [5] = '{0, 0, 0, 0, 0};
    int          n_pass = 0;
    int          n_fail = 0;

    gfx_core dut_i (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .line_start(line_start),
        .lhbl(lhbl), .lvbl(lvbl), .hdump(hdump), .vrender(vrender),
        .cs(cs), .cpu_rnw(cpu_rnw), .cpu_cen(cpu_cen), .addr(addr),
        .cpu_dout(cpu_dout), .rom_data(rom_data), .rom_ok(rom_ok), .gfx_en(gfx_en),
        .dout(dout), .cpu_irqn(cpu_irqn), .rom_cs(rom_cs), .rom_addr(rom_addr),
        .rom_obj_sel(rom_obj_sel), .pxl_out(pxl_out)
    );

    always #2 clk = ~clk;

    function automatic string test_name(input int t);
        case (t)
            0: return "registers";
            1: return "interrupt";
            2: return "rom_port";
            3: return "pixels";
            default: return "layer_disable";
        endcase
    endfunction

    // ROM contents mixed from every address bit
    function automatic logic [15:0] rom_pat(input logic [17:0] a);
        return a[15:0] * 16'h03b5 + (a[15:0] >> 7) + {14'd0, a[17:16]};
    endfunction

    function automatic logic [17:0] req_addr(input logic bank, input logic [7:0] line,
                                             input int word);
        return {6'd0, bank, line, 3'(word)};
    endfunction

    // Leftmost pixel sits in the top nibble
    function automatic logic [3:0] pix_at(input logic bank, input logic [7:0] line,
                                          input logic [4:0] pos);
        logic [15:0] w;
        w = rom_pat(req_addr(bank, line, int'(pos[4:2])));
        return 4'(w >> (4 * (3 - pos[1:0])));
    endfunction

    function automatic logic [6:0] expect_pxl(input logic [4:0] h);
        logic [4:0] tp;
        logic [3:0] tpx;
        logic [3:0] opx;
        tp  = h + regs_m[0][4:0];
        tpx = shown_en[0] ? pix_at(shown_tb, shown_tl, tp) : 4'd0;
        opx = shown_en[1] ? pix_at(shown_ob, shown_ol, h) : 4'd0;
        if (!lhbl || !lvbl)
            return 7'd0;
        if (opx == 4'd0 || (regs_m[6][3] && tpx != 4'd0))
            return {regs_m[6][5:4], 1'b1, tpx};
        return {regs_m[6][5:4], 1'b0, opx};
    endfunction

    task automatic report_value(input int t, input logic [31:0] e, input logic [31:0] a);
        errs[t]++;
        $display("Error: %s expected %0h actual %0h", test_name(t), e, a);
    endtask

    task automatic finish_test(input int t);
        $display("Test %s finished with %0d errors", test_name(t), errs[t]);
        if (errs[t] == 0)
            n_pass++;
        else
            n_fail++;
    endtask

    task automatic drive_video();
        pxl_cen    = clk_cnt[0];
        hdump      = 5'(clk_cnt >> 1);
        lhbl       = (clk_cnt >> 1) < 32;
        lvbl       = (vcnt != 5);
        vrender    = 8'((vcnt + 1) % 6);
        line_start = (clk_cnt == 0);
    endtask

    // Video timing, ROM model and cycle limit
    always @(posedge clk) begin
        #1;
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Timeout: the run did not end within %0d cycles", max_cycles);
            $display("Verification failed");
            $finish;
        end else begin
            if (clk_cnt == 111) begin
                clk_cnt = 0;
                vcnt = (vcnt == 5) ? 0 : vcnt + 1;
            end else begin
                clk_cnt++;
            end
            drive_video();
            if (!rom_cs) begin
                rom_pend = 1'b0;
                rom_ok   = 1'b0;
            end else if (!rom_pend) begin
                rom_pend = 1'b1;
                rcnt     = 1;
                wait_n   = 2 + ({$random(seed)} % 4);
                rom_data = rom_pat(rom_addr);
            end else begin
                rcnt++;
                if (rcnt >= wait_n)
                    rom_ok = 1'b1;
            end
        end
    end

    // ROM port and pixel checks sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (rom_cs && prev_cs)
                assert (rom_addr == prev_addr && rom_obj_sel == prev_sel)
                else report_value(dis_phase ? 4 : 2, {prev_sel, prev_addr},
                                  {rom_obj_sel, rom_addr});
            if (rom_cs && !prev_cs) begin
                if (rom_obj_sel) begin
                    assert (rom_addr == req_addr(fetch_ob, fetch_ol, obj_req))
                    else report_value(dis_phase ? 4 : 2,
                                      req_addr(fetch_ob, fetch_ol, obj_req), rom_addr);
                    obj_req++;
                end else begin
                    assert (rom_addr == req_addr(fetch_tb, fetch_tl, tile_req))
                    else report_value(dis_phase ? 4 : 2,
                                      req_addr(fetch_tb, fetch_tl, tile_req), rom_addr);
                    tile_req++;
                end
            end
            prev_cs   = rom_cs;
            prev_addr = rom_addr;
            prev_sel  = rom_obj_sel;
            if (line_start) begin
                if (lines_seen >= 1) begin
                    assert (tile_req == (fetch_en[0] ? 8 : 0))
                    else report_value(dis_phase ? 4 : 2, fetch_en[0] ? 8 : 0, tile_req);
                    assert (obj_req == (fetch_en[1] ? 8 : 0))
                    else report_value(dis_phase ? 4 : 2, fetch_en[1] ? 8 : 0, obj_req);
                end
                tile_req = 0;
                obj_req  = 0;
                lines_seen++;
                shown_tb = fetch_tb;
                shown_tl = fetch_tl;
                shown_ob = fetch_ob;
                shown_ol = fetch_ol;
                shown_en = fetch_en;
                fetch_tb = regs_m[3][0];
                fetch_tl = vrender + regs_m[2];
                fetch_ob = regs_m[3][3];
                fetch_ol = vrender;
                fetch_en = gfx_en;
            end
            if (pix_on && exp_ok)
                assert (pxl_out == exp_pxl)
                else report_value(dis_phase ? 4 : 3, exp_pxl, pxl_out);
            if (pxl_cen) begin
                exp_pxl = expect_pxl(hdump);
                exp_ok  = (lines_seen >= 2);
            end
        end
    end

    task automatic write_reg(input logic [2:0] a, input logic [7:0] d);
        @(posedge clk);
        #1;
        cs       = 1'b1;
        cpu_rnw  = 1'b0;
        cpu_cen  = 1'b1;
        addr     = a;
        cpu_dout = d;
        @(posedge clk);
        #1;
        cs        = 1'b0;
        cpu_rnw   = 1'b1;
        cpu_cen   = 1'b0;
        regs_m[a] = d;
    endtask

    task automatic read_check(input logic [2:0] a, input logic [7:0] e);
        @(posedge clk);
        #1;
        addr = a;
        @(negedge clk);
        assert (dout == e) else report_value(0, e, dout);
    endtask

    // Stops early in the vertical blank line once its fetch is done
    task automatic wait_vblank();
        @(posedge clk);
        while (!(vcnt == 5 && clk_cnt == 100))
            @(posedge clk);
    endtask

    initial begin
        for (int i = 0; i < 8; i++) begin
            regs_m[i] = 8'd0;
        end
        rst      = 1'b1;
        cs       = 1'b0;
        cpu_rnw  = 1'b1;
        cpu_cen  = 1'b0;
        addr     = 3'd0;
        cpu_dout = 8'd0;
        rom_data = 16'd0;
        rom_ok   = 1'b0;
        gfx_en   = 2'b11;
        drive_video();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < 8; i++) begin
            read_check(3'(i), 8'd0);
        end
        for (int i = 0; i < 8; i++) begin
            write_reg(3'(i), 8'(8'h5a ^ (i * 37)));
        end
        for (int i = 0; i < 8; i++) begin
            read_check(3'(i), 8'(8'h5a ^ (i * 37)));
        end
        for (int i = 0; i < 8; i++) begin
            write_reg(3'(i), 8'd0);
        end
        finish_test(0);

        // Scroll, bank, page and palette without tile priority
        wait_vblank();
        write_reg(3'd7, 8'h02);
        write_reg(3'd0, 8'h05);
        write_reg(3'd2, 8'h03);
        write_reg(3'd3, 8'h09);
        write_reg(3'd6, 8'h20);
        pix_on = 1'b1;

        wait_vblank();
        assert (cpu_irqn == 1'b0) else report_value(1, 0, cpu_irqn);
        write_reg(3'd7, 8'h00);
        @(negedge clk);
        assert (cpu_irqn == 1'b1) else report_value(1, 1, cpu_irqn);
        write_reg(3'd6, 8'h18);
        // Tile bank set with the object page clear
        write_reg(3'd3, 8'h01);

        wait_vblank();
        assert (cpu_irqn == 1'b1) else report_value(1, 1, cpu_irqn);
        finish_test(1);
        finish_test(2);
        finish_test(3);
        #1;
        dis_phase = 1'b1;
        gfx_en    = 2'b10;
        write_reg(3'd0, 8'h07);

        wait_vblank();
        #1;
        gfx_en = 2'b01;
        wait_vblank();
        #1;
        gfx_en = 2'b11;
        wait_vblank();
        finish_test(4);

        $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
source/gfx_pkg.sv
source/gfx_rom_if.sv
source/gfx_regs.sv
source/gfx_rom_arbiter.sv
source/gfx_layer_fetch.sv
source/gfx_mixer.sv
source/gfx_core.sv
verification/gfx_core_tb.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the gfx_core testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module gfx_core_tb -o gfx_core_sim &&
./obj_dir/gfx_core_sim | tee /dev/stderr | grep -q "Verification passed" &&
echo "Simulation run OK" ||
{ echo "Simulation run FAILED"; exit 1; }
